// File: rtl/fifoctl_pkg.sv
package fifoctl_pkg;

    // widest pointer the gray helpers handle, zero-extend narrower ones
    localparam int PTR_MAX = 16;

    typedef logic [PTR_MAX-1:0] ptr_t;

    // 16-bit threshold, one apb data half-word
    typedef logic [15:0] lvl_t;

    typedef struct packed {
        logic empty;
        logic ae;
        logic hf;
        logic af;
        logic full;
        logic error;
    } fifo_flags_t;

    // empty fifo status
    localparam fifo_flags_t FLAGS_RST = '{empty: 1'b1, ae: 1'b1, default: 1'b0};

    typedef struct packed {
        lvl_t ae_lvl;
        lvl_t af_lvl;
        logic err_sticky_n;  // 1 = error clears on next legal pop
    } pop_cfg_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [7:0] {
        REG_AE_LVL   = 8'h00,
        REG_AF_LVL   = 8'h04,
        REG_ERR_MODE = 8'h08,
        REG_COUNT    = 8'h0C
    } reg_addr_e;

    function automatic ptr_t bin2gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // prefix xor from the msb down
    function automatic ptr_t gray2bin(ptr_t gray);
        ptr_t bin;
        bin[PTR_MAX-1] = gray[PTR_MAX-1];
        for (int i = PTR_MAX - 2; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// File: rtl/gray_sync.sv
module gray_sync
#(
    parameter int WIDTH = 4,
    parameter int SYNC  = 2
)
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] ptr_gray,
    output logic [WIDTH-1:0] ptr_bin
);

    // stage 0 samples the other domain, stage SYNC-1 is safe to use
    logic [SYNC-1:0][WIDTH-1:0] sync_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_q <= '0;
        end
        else
        begin
            sync_q <= {sync_q[SYNC-2:0], ptr_gray};
        end
    end

    // back to binary in the receiving domain
    assign ptr_bin = WIDTH'(fifoctl_pkg::gray2bin(fifoctl_pkg::ptr_t'(sync_q[SYNC-1])));

endmodule

// File: rtl/push_ctrl.sv
module push_ctrl
#(
    parameter int ADDR_WIDTH = 3,
    parameter int AE_LVL     = 2,
    parameter int AF_LVL     = 2,
    parameter int ERR_MODE   = 0
)
(
    input  logic                     clk_push,
    input  logic                     rst_n,
    input  logic                     push_req_n,
    input  logic [ADDR_WIDTH:0]      rd_ptr_bin,
    output logic [ADDR_WIDTH-1:0]    wr_addr,
    output logic                     we_n,
    output logic [ADDR_WIDTH:0]      wr_ptr_gray,
    output fifoctl_pkg::fifo_flags_t push_flags,
    output logic [ADDR_WIDTH:0]      push_word_count
);

    localparam int PTR_W = ADDR_WIDTH + 1;
    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [PTR_W-1:0] wr_ptr;       // extra msb tells wrap
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [PTR_W-1:0] rd_ptr_prev;  // synced read pointer, one cycle back
    logic [PTR_W-1:0] pops_seen;
    logic [PTR_W-1:0] count_nxt;
    logic             push_en;

    assign push_en = ~push_req_n & ~push_flags.full;
    assign we_n    = ~push_en;  // write strobe to the ram, same cycle
    assign wr_addr = wr_ptr[ADDR_WIDTH-1:0];

    assign wr_ptr_nxt = wr_ptr + PTR_W'(push_en);

    // modulo difference, pointer may wrap between samples
    assign pops_seen = rd_ptr_bin - rd_ptr_prev;
    assign count_nxt = push_word_count + PTR_W'(push_en) - pops_seen;

    always_ff @(posedge clk_push or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr          <= '0;
            wr_ptr_gray     <= '0;
            rd_ptr_prev     <= '0;
            push_word_count <= '0;
            push_flags      <= fifoctl_pkg::FLAGS_RST;
        end
        else
        begin
            wr_ptr          <= wr_ptr_nxt;
            wr_ptr_gray     <= PTR_W'(fifoctl_pkg::bin2gray(fifoctl_pkg::ptr_t'(wr_ptr_nxt)));
            rd_ptr_prev     <= rd_ptr_bin;
            push_word_count <= count_nxt;

            // flags follow the next count
            push_flags.empty <= (count_nxt == '0);
            push_flags.ae    <= (count_nxt <= AE_LVL);
            push_flags.hf    <= (count_nxt >= DEPTH / 2);
            push_flags.af    <= (count_nxt >= DEPTH - AF_LVL);
            push_flags.full  <= (count_nxt == DEPTH);

            if (!push_req_n)
            begin
                if (push_flags.full)
                begin
                    push_flags.error <= 1'b1;  // push into a full fifo
                end
                else if (ERR_MODE != 0)
                begin
                    push_flags.error <= 1'b0;  // cleared by a legal push
                end
            end
        end
    end

endmodule

// File: rtl/pop_ctrl.sv
module pop_ctrl
#(
    parameter int ADDR_WIDTH = 3
)
(
    input  logic                     clk_pop,
    input  logic                     rst_n,
    input  logic                     pop_req_n,
    input  logic [ADDR_WIDTH:0]      wr_ptr_bin,
    input  fifoctl_pkg::pop_cfg_t    pop_cfg,
    output logic [ADDR_WIDTH-1:0]    rd_addr,
    output logic [ADDR_WIDTH:0]      rd_ptr_gray,
    output fifoctl_pkg::fifo_flags_t pop_flags,
    output logic [ADDR_WIDTH:0]      pop_word_count
);

    localparam int PTR_W = ADDR_WIDTH + 1;
    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [PTR_W-1:0] wr_ptr_prev;
    logic [PTR_W-1:0] pushes_seen;
    logic [PTR_W-1:0] count_nxt;
    logic [16:0]      af_sum;  // count plus af level, no underflow
    logic             pop_en;

    assign pop_en  = ~pop_req_n & ~pop_flags.empty;
    assign rd_addr = rd_ptr[ADDR_WIDTH-1:0];

    assign rd_ptr_nxt = rd_ptr + PTR_W'(pop_en);

    assign pushes_seen = wr_ptr_bin - wr_ptr_prev;
    assign count_nxt   = pop_word_count + pushes_seen - PTR_W'(pop_en);

    // af when count >= depth - af_lvl, rearranged
    assign af_sum = 17'(count_nxt) + 17'(pop_cfg.af_lvl);

    always_ff @(posedge clk_pop or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_ptr         <= '0;
            rd_ptr_gray    <= '0;
            wr_ptr_prev    <= '0;
            pop_word_count <= '0;
            pop_flags      <= fifoctl_pkg::FLAGS_RST;
        end
        else
        begin
            rd_ptr         <= rd_ptr_nxt;
            rd_ptr_gray    <= PTR_W'(fifoctl_pkg::bin2gray(fifoctl_pkg::ptr_t'(rd_ptr_nxt)));
            wr_ptr_prev    <= wr_ptr_bin;
            pop_word_count <= count_nxt;

            // thresholds from the register block
            pop_flags.empty <= (count_nxt == '0);
            pop_flags.ae    <= (fifoctl_pkg::lvl_t'(count_nxt) <= pop_cfg.ae_lvl);
            pop_flags.hf    <= (count_nxt >= DEPTH / 2);
            pop_flags.af    <= (af_sum >= 17'(DEPTH));
            pop_flags.full  <= (count_nxt == DEPTH);

            if (!pop_req_n)
            begin
                if (pop_flags.empty)
                begin
                    pop_flags.error <= 1'b1;  // underflow attempt
                end
                else if (pop_cfg.err_sticky_n)
                begin
                    pop_flags.error <= 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/pop_cfg_regs.sv
module pop_cfg_regs
#(
    parameter int RD_AE_LVL = 2,
    parameter int RD_AF_LVL = 2,
    parameter int ERR_MODE  = 0
)
(
    input  logic                  clk_pop,
    input  logic                  rst_n,
    input  fifoctl_pkg::apb_req_t apb_req,
    input  fifoctl_pkg::lvl_t     pop_word_count,
    output fifoctl_pkg::apb_rsp_t apb_rsp,
    output fifoctl_pkg::pop_cfg_t pop_cfg
);

    fifoctl_pkg::reg_addr_e reg_addr;
    logic                   access;   // apb access phase
    logic                   addr_ok;
    logic                   wr_ok;    // offset accepts writes
    logic                   wr_en;
    logic [31:0]            rd_data;

    assign reg_addr = fifoctl_pkg::reg_addr_e'(apb_req.paddr);
    assign access   = apb_req.psel & apb_req.penable;

    always_comb
    begin
        rd_data = '0;
        addr_ok = 1'b1;
        wr_ok   = 1'b1;
        case (reg_addr)
            fifoctl_pkg::REG_AE_LVL:   rd_data = {16'h0, pop_cfg.ae_lvl};
            fifoctl_pkg::REG_AF_LVL:   rd_data = {16'h0, pop_cfg.af_lvl};
            fifoctl_pkg::REG_ERR_MODE: rd_data = {31'h0, pop_cfg.err_sticky_n};
            fifoctl_pkg::REG_COUNT:
            begin
                rd_data = {16'h0, pop_word_count};
                wr_ok   = 1'b0;  // read only
            end
            default:
            begin
                addr_ok = 1'b0;
                wr_ok   = 1'b0;
            end
        endcase
    end

    assign wr_en = access & apb_req.pwrite & wr_ok;

    // no wait states
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.prdata  = rd_data;  // zero for unknown offsets
    assign apb_rsp.pslverr = access & (~addr_ok | (apb_req.pwrite & ~wr_ok));

    always_ff @(posedge clk_pop or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pop_cfg.ae_lvl       <= fifoctl_pkg::lvl_t'(RD_AE_LVL);
            pop_cfg.af_lvl       <= fifoctl_pkg::lvl_t'(RD_AF_LVL);
            pop_cfg.err_sticky_n <= (ERR_MODE != 0);
        end
        else if (wr_en)
        begin
            case (reg_addr)
                fifoctl_pkg::REG_AE_LVL:   pop_cfg.ae_lvl       <= apb_req.pwdata[15:0];
                fifoctl_pkg::REG_AF_LVL:   pop_cfg.af_lvl       <= apb_req.pwdata[15:0];
                fifoctl_pkg::REG_ERR_MODE: pop_cfg.err_sticky_n <= apb_req.pwdata[0];
                default:                   ;
            endcase
        end
    end

endmodule

// File: rtl/fifoctl_s2_sf.sv
module fifoctl_s2_sf
#(
    parameter int ADDR_WIDTH = 3,   // depth is 2**ADDR_WIDTH
    parameter int WR_SYNC    = 2,   // 2 to 4 stages
    parameter int RD_SYNC    = 2,
    parameter int WR_AE_LVL  = 2,
    parameter int WR_AF_LVL  = 2,
    parameter int RD_AE_LVL  = 2,   // reset values of the pop registers
    parameter int RD_AF_LVL  = 2,
    parameter int ERR_MODE   = 0    // 0 sticky error, 1 cleared by legal request
)
(
    input  logic                     clk_push,
    input  logic                     clk_pop,
    input  logic                     rst_n,
    input  logic                     push_req_n,
    input  logic                     pop_req_n,
    output logic [ADDR_WIDTH-1:0]    wr_addr,
    output logic                     we_n,
    output logic [ADDR_WIDTH-1:0]    rd_addr,
    output fifoctl_pkg::fifo_flags_t push_flags,
    output fifoctl_pkg::fifo_flags_t pop_flags,
    output logic [ADDR_WIDTH:0]      push_word_count,
    output logic [ADDR_WIDTH:0]      pop_word_count,
    input  fifoctl_pkg::apb_req_t    apb_req,
    output fifoctl_pkg::apb_rsp_t    apb_rsp
);

    logic [ADDR_WIDTH:0]   wr_ptr_gray;  // clk_push domain
    logic [ADDR_WIDTH:0]   wr_ptr_bin;   // clk_pop domain
    logic [ADDR_WIDTH:0]   rd_ptr_gray;  // clk_pop domain
    logic [ADDR_WIDTH:0]   rd_ptr_bin;   // clk_push domain
    fifoctl_pkg::pop_cfg_t pop_cfg;

    push_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .AE_LVL     (WR_AE_LVL),
        .AF_LVL     (WR_AF_LVL),
        .ERR_MODE   (ERR_MODE)
    ) u_push_ctrl (
        .clk_push        (clk_push),
        .rst_n           (rst_n),
        .push_req_n      (push_req_n),
        .rd_ptr_bin      (rd_ptr_bin),
        .wr_addr         (wr_addr),
        .we_n            (we_n),
        .wr_ptr_gray     (wr_ptr_gray),
        .push_flags      (push_flags),
        .push_word_count (push_word_count)
    );

    gray_sync #(.WIDTH(ADDR_WIDTH + 1), .SYNC(RD_SYNC)) u_sync_wr2rd (
        .clk      (clk_pop),
        .rst_n    (rst_n),
        .ptr_gray (wr_ptr_gray),
        .ptr_bin  (wr_ptr_bin)
    );

    gray_sync #(.WIDTH(ADDR_WIDTH + 1), .SYNC(WR_SYNC)) u_sync_rd2wr (
        .clk      (clk_push),
        .rst_n    (rst_n),
        .ptr_gray (rd_ptr_gray),
        .ptr_bin  (rd_ptr_bin)
    );

    pop_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_pop_ctrl (
        .clk_pop        (clk_pop),
        .rst_n          (rst_n),
        .pop_req_n      (pop_req_n),
        .wr_ptr_bin     (wr_ptr_bin),
        .pop_cfg        (pop_cfg),
        .rd_addr        (rd_addr),
        .rd_ptr_gray    (rd_ptr_gray),
        .pop_flags      (pop_flags),
        .pop_word_count (pop_word_count)
    );

    // count read back zero-extended to the 16-bit field
    pop_cfg_regs #(
        .RD_AE_LVL (RD_AE_LVL),
        .RD_AF_LVL (RD_AF_LVL),
        .ERR_MODE  (ERR_MODE)
    ) u_pop_cfg_regs (
        .clk_pop        (clk_pop),
        .rst_n          (rst_n),
        .apb_req        (apb_req),
        .pop_word_count (fifoctl_pkg::lvl_t'(pop_word_count)),
        .apb_rsp        (apb_rsp),
        .pop_cfg        (pop_cfg)
    );

endmodule

// File: sim/clk_gen.sv
module clk_gen
#(
    parameter int PERIOD = 100,
    parameter int PHASE  = 0    // delay before the first half period
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        #(PHASE);
        forever
        begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// File: sim/tb_fifoctl.sv
module tb_fifoctl;

    localparam int ADDR_WIDTH = 3;
    localparam int DEPTH      = 1 << ADDR_WIDTH;
    localparam int WR_AE_LVL  = 2;
    localparam int WR_AF_LVL  = 2;
    localparam int RD_AE_LVL  = 2;
    localparam int RD_AF_LVL  = 2;
    localparam int ERR_MODE   = 0;
    localparam int N_FIXED    = 13;
    localparam int N_RAND     = 8;
    localparam int N_ROWS     = N_FIXED + N_RAND;
    localparam int TIMEOUT    = N_ROWS * 40 * 100;

    // exp_count only used when has_exp is set
    typedef struct packed {
        logic [3:0]  n_push;
        logic [3:0]  n_pop;
        logic        apb_en;
        logic [7:0]  apb_addr;
        logic [15:0] apb_data;
        logic        has_exp;
        logic [3:0]  exp_count;
    } row_t;

    logic                     clk_push;
    logic                     clk_pop;
    logic                     rst_n;
    logic                     push_req_n;
    logic                     pop_req_n;
    logic [ADDR_WIDTH-1:0]    wr_addr;
    logic                     we_n;
    logic [ADDR_WIDTH-1:0]    rd_addr;
    fifoctl_pkg::fifo_flags_t push_flags;
    fifoctl_pkg::fifo_flags_t pop_flags;
    logic [ADDR_WIDTH:0]      push_word_count;
    logic [ADDR_WIDTH:0]      pop_word_count;
    fifoctl_pkg::apb_req_t    apb_req;
    fifoctl_pkg::apb_rsp_t    apb_rsp;

    // software model of the fifo
    int     model_count;
    int     model_wr;
    int     model_rd;
    int     model_ae;
    int     model_af;
    logic   model_clr;
    logic   model_push_err;
    logic   model_pop_err;
    integer seed;
    int     err_count;
    row_t   rows [N_ROWS];

    clk_gen #(.PERIOD(100), .PHASE(0))  u_clk_pop  (.clk(clk_pop));
    clk_gen #(.PERIOD(100), .PHASE(37)) u_clk_push (.clk(clk_push));  // skewed domain

    fifoctl_s2_sf #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .WR_SYNC    (2),
        .RD_SYNC    (2),
        .WR_AE_LVL  (WR_AE_LVL),
        .WR_AF_LVL  (WR_AF_LVL),
        .RD_AE_LVL  (RD_AE_LVL),
        .RD_AF_LVL  (RD_AF_LVL),
        .ERR_MODE   (ERR_MODE)
    ) u_fifoctl_s2_sf (
        .clk_push        (clk_push),
        .clk_pop         (clk_pop),
        .rst_n           (rst_n),
        .push_req_n      (push_req_n),
        .pop_req_n       (pop_req_n),
        .wr_addr         (wr_addr),
        .we_n            (we_n),
        .rd_addr         (rd_addr),
        .push_flags      (push_flags),
        .pop_flags       (pop_flags),
        .push_word_count (push_word_count),
        .pop_word_count  (pop_word_count),
        .apb_req         (apb_req),
        .apb_rsp         (apb_rsp)
    );

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        err_count++;
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic row_t make_row(int np, int npop, logic apb_en, logic [7:0] addr,
                                      logic [15:0] data, logic has_exp, int exp);
        row_t row;
        row.n_push    = 4'(np);
        row.n_pop     = 4'(npop);
        row.apb_en    = apb_en;
        row.apb_addr  = addr;
        row.apb_data  = data;
        row.has_exp   = has_exp;
        row.exp_count = 4'(exp);
        return row;
    endfunction

    // threshold rules applied to a count
    function automatic fifoctl_pkg::fifo_flags_t exp_flags(int cnt, int ae, int af, logic err);
        fifoctl_pkg::fifo_flags_t f;
        f.empty = (cnt == 0);
        f.ae    = (cnt <= ae);
        f.hf    = (cnt >= DEPTH / 2);
        f.af    = (cnt + af >= DEPTH);
        f.full  = (cnt == DEPTH);
        f.error = err;
        return f;
    endfunction

    task automatic idle(input int n);
        fork
            repeat (n) @(posedge clk_push);
            repeat (n) @(posedge clk_pop);
        join
        #10;
    endtask

    task automatic push_words(input int n);
        int   i;
        logic accept;
        for (i = 0; i < n; i++)
        begin
            @(posedge clk_push);
            #10 push_req_n = 1'b0;
            #20;
            accept = (model_count < DEPTH);
            if (accept)
            begin
                model_count++;
                model_wr++;
                if (ERR_MODE != 0)
                begin
                    model_push_err = 1'b0;
                end
            end
            else
            begin
                model_push_err = 1'b1;  // overflow attempt
            end
            assert (we_n == !accept) else fail_value("we_n", we_n, !accept);
        end
        @(posedge clk_push);
        #10 push_req_n = 1'b1;
    endtask

    task automatic pop_words(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            @(posedge clk_pop);
            #10 pop_req_n = 1'b0;
            if (model_count > 0)
            begin
                model_count--;
                model_rd++;
                if (model_clr)
                begin
                    model_pop_err = 1'b0;
                end
            end
            else
            begin
                model_pop_err = 1'b1;
            end
        end
        @(posedge clk_pop);
        #10 pop_req_n = 1'b1;
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        @(posedge clk_pop);
        #10;
        apb_req.psel    = 1'b1;  // setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk_pop);
        #10 apb_req.penable = 1'b1;
        #40;
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        assert (apb_rsp.pready) else fail_value("pready", apb_rsp.pready, 1);
        @(posedge clk_pop);  // access edge, write lands here
        #10 apb_req = '0;
    endtask

    task automatic check_state();
        fifoctl_pkg::fifo_flags_t pf;
        fifoctl_pkg::fifo_flags_t rf;
        pf = exp_flags(model_count, WR_AE_LVL, WR_AF_LVL, model_push_err);
        rf = exp_flags(model_count, model_ae, model_af, model_pop_err);
        assert (push_word_count == model_count)
            else fail_value("push_word_count", push_word_count, model_count);
        assert (pop_word_count == model_count)
            else fail_value("pop_word_count", pop_word_count, model_count);
        assert (push_flags == pf) else fail_value("push_flags", push_flags, pf);
        assert (pop_flags == rf) else fail_value("pop_flags", pop_flags, rf);
        assert (wr_addr == model_wr % DEPTH) else fail_value("wr_addr", wr_addr, model_wr % DEPTH);
        assert (rd_addr == model_rd % DEPTH) else fail_value("rd_addr", rd_addr, model_rd % DEPTH);
        assert (we_n == 1'b1) else fail_value("we_n", we_n, 1);
        assert (apb_rsp.pslverr == 1'b0) else fail_value("pslverr", apb_rsp.pslverr, 0);
    endtask

    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish in the expected time");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [31:0] rdata;
        logic        slverr;
        int          r;

        rst_n          = 1'b0;
        push_req_n     = 1'b1;
        pop_req_n      = 1'b1;
        apb_req        = '0;
        seed           = 32'h6e527e17;
        err_count      = 0;
        model_count    = 0;
        model_wr       = 0;
        model_rd       = 0;
        model_ae       = RD_AE_LVL;
        model_af       = RD_AF_LVL;
        model_clr      = (ERR_MODE != 0);
        model_push_err = 1'b0;
        model_pop_err  = 1'b0;

        // pushes, pops, apb write, expected count
        rows[0]  = make_row(1, 0, 0, 8'h00, 16'h0, 1, 1);
        rows[1]  = make_row(3, 0, 0, 8'h00, 16'h0, 1, 4);
        rows[2]  = make_row(4, 0, 0, 8'h00, 16'h0, 1, 8);
        rows[3]  = make_row(2, 0, 0, 8'h00, 16'h0, 1, 8);   // overflow
        rows[4]  = make_row(0, 3, 0, 8'h00, 16'h0, 1, 5);
        rows[5]  = make_row(1, 0, 0, 8'h00, 16'h0, 1, 6);   // push error stays
        rows[6]  = make_row(0, 6, 0, 8'h00, 16'h0, 1, 0);
        rows[7]  = make_row(0, 2, 0, 8'h00, 16'h0, 1, 0);   // underflow
        rows[8]  = make_row(2, 0, 1, 8'h08, 16'h1, 1, 2);
        rows[9]  = make_row(0, 1, 0, 8'h00, 16'h0, 1, 1);   // pop error clears
        rows[10] = make_row(3, 0, 1, 8'h00, 16'h4, 1, 4);
        rows[11] = make_row(3, 0, 1, 8'h04, 16'h1, 1, 7);
        rows[12] = make_row(0, 1, 0, 8'h00, 16'h0, 1, 6);   // push af set, pop af clear
        for (r = N_FIXED; r < N_ROWS; r++)
        begin
            rows[r] = make_row($unsigned($random(seed)) % 9, $unsigned($random(seed)) % 9,
                               0, 8'h00, 16'h0, 0, 0);
        end

        repeat (3) @(posedge clk_pop);
        #10 rst_n = 1'b1;
        idle(2);
        check_state();

        for (r = 0; r < N_ROWS; r++)
        begin
            if (rows[r].apb_en)
            begin
                apb_xfer(1'b1, rows[r].apb_addr, 32'(rows[r].apb_data), rdata, slverr);
                assert (!slverr) else fail_value("pslverr", slverr, 0);
                case (rows[r].apb_addr)
                    8'h00:   model_ae = rows[r].apb_data;
                    8'h04:   model_af = rows[r].apb_data;
                    default: model_clr = rows[r].apb_data[0];
                endcase
            end
            push_words(rows[r].n_push);
            idle(6);  // let the pop side see the pushes
            pop_words(rows[r].n_pop);
            idle(12);
            check_state();
            if (rows[r].has_exp)
            begin
                assert (pop_word_count == rows[r].exp_count)
                    else fail_value("pop_word_count", pop_word_count, rows[r].exp_count);
            end
        end

        push_words(1);  // count read back below is never zero
        idle(12);
        check_state();

        // register block accesses
        apb_xfer(1'b0, 8'h0C, 32'h0, rdata, slverr);
        assert (rdata == model_count) else fail_value("prdata", rdata, model_count);
        assert (!slverr) else fail_value("pslverr", slverr, 0);
        apb_xfer(1'b1, 8'h0C, 32'h3, rdata, slverr);
        assert (slverr) else fail_value("pslverr", slverr, 1);
        apb_xfer(1'b1, 8'h10, 32'h7, rdata, slverr);
        assert (slverr) else fail_value("pslverr", slverr, 1);
        apb_xfer(1'b0, 8'h10, 32'h0, rdata, slverr);
        assert (slverr) else fail_value("pslverr", slverr, 1);
        assert (rdata == 32'h0) else fail_value("prdata", rdata, 0);
        apb_xfer(1'b0, 8'h00, 32'h0, rdata, slverr);
        assert (rdata == model_ae) else fail_value("prdata", rdata, model_ae);
        idle(2);
        check_state();  // count untouched by the bad writes

        if (err_count == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/fifoctl_pkg.sv
rtl/gray_sync.sv
rtl/push_ctrl.sv
rtl/pop_ctrl.sv
rtl/pop_cfg_regs.sv
rtl/fifoctl_s2_sf.sv
sim/clk_gen.sv
sim/tb_fifoctl.sv

// File: Bender.yml
package:
  name: fifoctl_s2_sf

sources:
  - rtl/fifoctl_pkg.sv
  - rtl/gray_sync.sv
  - rtl/push_ctrl.sv
  - rtl/pop_ctrl.sv
  - rtl/pop_cfg_regs.sv
  - rtl/fifoctl_s2_sf.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/tb_fifoctl.sv
